//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f sources.f

out=$(./obj_dir/Vtb_top || true)
echo "$out"
echo "$out" | grep -qx "TB PASSED"

//--- source/branch_exec_top.sv
`timescale 1ns/1ps

module branch_exec_top #(
    parameter int RS_DEPTH = 16  // power of two
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  branch_pkg::br_dispatch_t dispatch_inst,
    input  branch_pkg::cdb_result_t  alu_result,
    input  branch_pkg::cdb_result_t  mul_result,
    input  branch_pkg::cdb_result_t  div_result,
    input  branch_pkg::cdb_result_t  load_result,  // valid is the memread qualifier
    output logic                     rs_full,
    output logic                     resolve_valid,
    output branch_pkg::br_resolve_t  resolve_out
);
    import branch_pkg::*;

    logic      issue_valid;
    br_issue_t issue_inst;

    branch_rs #(
        .RS_DEPTH(RS_DEPTH)
    ) u_rs (
        .clk           (clk),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_inst (dispatch_inst),
        .alu_result    (alu_result),
        .mul_result    (mul_result),
        .div_result    (div_result),
        .load_result   (load_result),
        .rs_full       (rs_full),
        .issue_valid   (issue_valid),
        .issue_inst    (issue_inst)
    );

    branch_resolve u_resolve (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_inst   (issue_inst),
        .resolve_valid(resolve_valid),
        .resolve_out  (resolve_out)
    );

endmodule

//--- source/branch_pkg.sv
package branch_pkg;

    typedef logic [7:0]  phys_tag_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_num_t;
    typedef logic [2:0]  funct3_t;

    // branch conditions, RV32I encoding
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef struct packed {
        inst_num_t inst_num;
        word_t     pc;
        phys_tag_t rd;
        logic      is_jump;    // register-indirect jump
        logic      is_branch;
        funct3_t   funct3;
        word_t     imm;
        phys_tag_t src1;
        phys_tag_t src2;
        word_t     src1_data;
        word_t     src2_data;
        logic      src1_ready;
        logic      src2_ready;
        logic      pred_taken; // fetch prediction
        logic      btb_hit;
    } br_dispatch_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        word_t     data;
    } cdb_result_t;

    typedef struct packed {
        inst_num_t inst_num;
        word_t     pc;
        phys_tag_t rd;
        logic      is_jump;
        logic      is_branch;
        funct3_t   funct3;
        word_t     imm;
        word_t     op1;
        word_t     op2;
        logic      pred_taken;
        logic      btb_hit;
    } br_issue_t;

    typedef struct packed {
        inst_num_t inst_num;
        phys_tag_t rd;
        logic      taken;
        logic      mispredict;
        word_t     redirect_pc;
        word_t     link_data;  // jumps only
    } br_resolve_t;

endpackage

//--- source/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  branch_pkg::br_issue_t   issue_inst,
    output logic                    resolve_valid,
    output branch_pkg::br_resolve_t resolve_out
);
    import branch_pkg::*;

    logic        cond;
    logic        taken;
    word_t       target;
    word_t       pc_plus4;
    br_resolve_t result;

    always_comb begin
        case (issue_inst.funct3)
            F3_BEQ:  cond = (issue_inst.op1 == issue_inst.op2);
            F3_BNE:  cond = (issue_inst.op1 != issue_inst.op2);
            F3_BLT:  cond = ($signed(issue_inst.op1) < $signed(issue_inst.op2));
            F3_BGE:  cond = ($signed(issue_inst.op1) >= $signed(issue_inst.op2));
            F3_BLTU: cond = (issue_inst.op1 < issue_inst.op2);
            F3_BGEU: cond = (issue_inst.op1 >= issue_inst.op2);
            default: cond = 1'b0;  // reserved encodings never taken
        endcase
    end

    assign pc_plus4 = issue_inst.pc + 32'd4;

    always_comb begin
        if (issue_inst.is_jump) begin
            taken  = 1'b1;
            target = (issue_inst.op1 + issue_inst.imm) & ~32'd1;  // jalr clears bit 0
        end else begin
            taken  = issue_inst.is_branch && cond;
            target = issue_inst.pc + issue_inst.imm;
        end

        result.inst_num    = issue_inst.inst_num;
        result.rd          = issue_inst.rd;
        result.taken       = taken;
        // taken without a btb entry means fetch had no target
        result.mispredict  = (taken != issue_inst.pred_taken) ||
                             (taken && !issue_inst.btb_hit);
        result.redirect_pc = taken ? target : pc_plus4;
        result.link_data   = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_valid <= 1'b0;
        end else begin
            resolve_valid <= issue_valid;
            if (issue_valid) begin
                resolve_out <= result;
            end
        end
    end

endmodule

//--- source/branch_rs.sv
`timescale 1ns/1ps

module branch_rs #(
    parameter int RS_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  branch_pkg::br_dispatch_t dispatch_inst,
    input  branch_pkg::cdb_result_t  alu_result,
    input  branch_pkg::cdb_result_t  mul_result,
    input  branch_pkg::cdb_result_t  div_result,
    input  branch_pkg::cdb_result_t  load_result,
    output logic                     rs_full,
    output logic                     issue_valid,
    output branch_pkg::br_issue_t    issue_inst
);
    import branch_pkg::*;

    localparam int PTR_W = $clog2(RS_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;

    // fields that ride along untouched until issue
    typedef struct packed {
        inst_num_t inst_num;
        word_t     pc;
        phys_tag_t rd;
        logic      is_jump;
        logic      is_branch;
        funct3_t   funct3;
        word_t     imm;
        logic      pred_taken;
        logic      btb_hit;
    } rs_payload_t;

    typedef struct packed {
        logic  ready;
        word_t data;
    } operand_t;

    rs_payload_t        payload [RS_DEPTH];
    phys_tag_t          src1_tag [RS_DEPTH];
    phys_tag_t          src2_tag [RS_DEPTH];
    word_t              src1_val [RS_DEPTH];
    word_t              src2_val [RS_DEPTH];
    logic [RS_DEPTH-1:0] src1_rdy;
    logic [RS_DEPTH-1:0] src2_rdy;
    logic [RS_DEPTH-1:0] occupied;

    ptr_t   head;
    ptr_t   tail;
    count_t count;

    rs_payload_t disp_payload;
    operand_t    disp_op1;
    operand_t    disp_op2;
    operand_t    wake_op1 [RS_DEPTH];
    operand_t    wake_op2 [RS_DEPTH];
    logic        head_ready;

    // bus priority alu, mul, div, load
    function automatic operand_t pick_operand(
        input phys_tag_t   tag,
        input logic        ready,
        input word_t       data,
        input cdb_result_t alu,
        input cdb_result_t mul,
        input cdb_result_t div,
        input cdb_result_t load
    );
        operand_t op;
        op.ready = ready;
        op.data  = data;
        if (!ready) begin
            if (alu.valid && alu.tag == tag) begin
                op.ready = 1'b1;
                op.data  = alu.data;
            end else if (mul.valid && mul.tag == tag) begin
                op.ready = 1'b1;
                op.data  = mul.data;
            end else if (div.valid && div.tag == tag) begin
                op.ready = 1'b1;
                op.data  = div.data;
            end else if (load.valid && load.tag == tag) begin
                op.ready = 1'b1;
                op.data  = load.data;
            end
        end
        return op;
    endfunction

    always_comb begin
        disp_payload.inst_num   = dispatch_inst.inst_num;
        disp_payload.pc         = dispatch_inst.pc;
        disp_payload.rd         = dispatch_inst.rd;
        disp_payload.is_jump    = dispatch_inst.is_jump;
        disp_payload.is_branch  = dispatch_inst.is_branch;
        disp_payload.funct3     = dispatch_inst.funct3;
        disp_payload.imm        = dispatch_inst.imm;
        disp_payload.pred_taken = dispatch_inst.pred_taken;
        disp_payload.btb_hit    = dispatch_inst.btb_hit;

        disp_op1 = pick_operand(dispatch_inst.src1, dispatch_inst.src1_ready,
                                dispatch_inst.src1_data, alu_result, mul_result,
                                div_result, load_result);
        disp_op2 = pick_operand(dispatch_inst.src2, dispatch_inst.src2_ready,
                                dispatch_inst.src2_data, alu_result, mul_result,
                                div_result, load_result);

        for (int i = 0; i < RS_DEPTH; i++) begin
            wake_op1[i] = pick_operand(src1_tag[i], src1_rdy[i], src1_val[i],
                                       alu_result, mul_result, div_result, load_result);
            wake_op2[i] = pick_operand(src2_tag[i], src2_rdy[i], src2_val[i],
                                       alu_result, mul_result, div_result, load_result);
        end
    end

    assign head_ready = occupied[head] && src1_rdy[head] && src2_rdy[head];
    assign rs_full    = (count == count_t'(RS_DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            occupied    <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= head_ready;

            // wakeup, only entries still in the queue
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (occupied[i]) begin
                    src1_rdy[i] <= wake_op1[i].ready;
                    src1_val[i] <= wake_op1[i].data;
                    src2_rdy[i] <= wake_op2[i].ready;
                    src2_val[i] <= wake_op2[i].data;
                end
            end

            if (head_ready) begin
                issue_inst.inst_num   <= payload[head].inst_num;
                issue_inst.pc         <= payload[head].pc;
                issue_inst.rd         <= payload[head].rd;
                issue_inst.is_jump    <= payload[head].is_jump;
                issue_inst.is_branch  <= payload[head].is_branch;
                issue_inst.funct3     <= payload[head].funct3;
                issue_inst.imm        <= payload[head].imm;
                issue_inst.op1        <= src1_val[head];
                issue_inst.op2        <= src2_val[head];
                issue_inst.pred_taken <= payload[head].pred_taken;
                issue_inst.btb_hit    <= payload[head].btb_hit;
                occupied[head]        <= 1'b0;
                head                  <= head + 1'b1;
            end

            // tail slot is free here, so no clash with issue or wakeup
            if (dispatch_valid) begin
                payload[tail]  <= disp_payload;
                src1_tag[tail] <= dispatch_inst.src1;
                src2_tag[tail] <= dispatch_inst.src2;
                src1_rdy[tail] <= disp_op1.ready;
                src1_val[tail] <= disp_op1.data;
                src2_rdy[tail] <= disp_op2.ready;
                src2_val[tail] <= disp_op2.data;
                occupied[tail] <= 1'b1;
                tail           <= tail + 1'b1;
            end

            count <= count + count_t'(dispatch_valid) - count_t'(head_ready);
        end
    end

endmodule

//--- sources.f
source/branch_pkg.sv
source/branch_rs.sv
source/branch_resolve.sv
source/branch_exec_top.sv
verif/branch_asserts.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- verif/branch_asserts.sv
`timescale 1ns/1ps

module branch_asserts #(
    parameter int RS_DEPTH = 16
) (
    input logic clk,
    input logic reset,
    input logic dispatch_valid,
    input logic rs_full,
    input logic issue_valid,
    input logic resolve_valid
);
    int occupancy;       // entries held as counted from dispatch and issue pulses
    int fail_count = 0;  // failed assertions so far

    always @(posedge clk) begin
        if (reset) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(dispatch_valid) - int'(issue_valid);
        end
    end

    no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (reset) !(dispatch_valid && rs_full)
    ) else begin
        $error("dispatch strobe while the station is full");
        fail_count++;
    end

    issue_low_in_reset: assert property (@(posedge clk) reset |=> !issue_valid)
        else begin
            $error("issue_valid high during reset");
            fail_count++;
        end

    resolve_follows_issue: assert property (
        @(posedge clk) disable iff (reset) resolve_valid == $past(issue_valid)
    ) else begin
        $error("resolve_valid is not issue_valid delayed by one cycle");
        fail_count++;
    end

    occupancy_bounded: assert property (
        @(posedge clk) disable iff (reset) occupancy <= RS_DEPTH
    ) else begin
        $error("station holds more entries than it has");
        fail_count++;
    end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int RS_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  branch_pkg::br_dispatch_t dispatch_inst,
    input  branch_pkg::cdb_result_t  alu_result,
    input  branch_pkg::cdb_result_t  mul_result,
    input  branch_pkg::cdb_result_t  div_result,
    input  branch_pkg::cdb_result_t  load_result,
    input  logic                     rs_full,
    input  logic                     resolve_valid,
    input  branch_pkg::br_resolve_t  resolve_out,
    output int                       error_count,
    output int                       outstanding
);
    import branch_pkg::*;

    br_dispatch_t pending [$];   // dispatched, not issued yet
    br_resolve_t  expect_q [$];  // issued, resolve still due
    logic         jump_q [$];
    cdb_result_t  buses [4];
    br_dispatch_t e;
    br_resolve_t  want;
    logic         is_jump;

    assign buses[0] = alu_result;
    assign buses[1] = mul_result;
    assign buses[2] = div_result;
    assign buses[3] = load_result;

    // operand update from the buses; alu scanned last so it wins
    function automatic logic [32:0] captured(phys_tag_t tag, logic ready, word_t data);
        logic [32:0] v;
        v = {ready, data};
        for (int k = 3; k >= 0; k--) begin
            if (!ready && buses[k].valid && buses[k].tag == tag) begin
                v = {1'b1, buses[k].data};
            end
        end
        return v;
    endfunction

    function automatic br_dispatch_t wake(br_dispatch_t d);
        {d.src1_ready, d.src1_data} = captured(d.src1, d.src1_ready, d.src1_data);
        {d.src2_ready, d.src2_data} = captured(d.src2, d.src2_ready, d.src2_data);
        return d;
    endfunction

    function automatic br_resolve_t expected_resolve(br_dispatch_t d);
        br_resolve_t r;
        word_t       sum;
        logic        eq;
        logic        lt_u;
        logic        lt_s;
        logic        cond;
        eq   = d.src1_data == d.src2_data;
        lt_u = d.src1_data < d.src2_data;
        // signs differ, the negative one is less
        lt_s = (d.src1_data[31] != d.src2_data[31]) ? d.src1_data[31] : lt_u;
        case (d.funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;
            default: cond = 1'b0;
        endcase
        sum           = d.src1_data + d.imm;
        r.inst_num    = d.inst_num;
        r.rd          = d.rd;
        r.taken       = d.is_jump || (d.is_branch && cond);
        r.link_data   = d.pc + 32'd4;
        r.mispredict  = r.taken ? (!d.pred_taken || !d.btb_hit) : d.pred_taken;
        if (!r.taken) begin
            r.redirect_pc = r.link_data;
        end else begin
            r.redirect_pc = d.is_jump ? {sum[31:1], 1'b0} : d.pc + d.imm;
        end
        return r;
    endfunction

    task automatic compare_field(string name, word_t got, word_t exp_val);
        if (got !== exp_val) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp_val);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pending.delete();
            expect_q.delete();
            jump_q.delete();
            error_count = 0;
        end else begin
            if (rs_full !== (pending.size() == RS_DEPTH)) begin
                $display("Mismatch at %0t: rs_full is %b with %0d entries queued",
                         $time, rs_full, pending.size());
                error_count++;
            end
            if (resolve_valid && expect_q.size() == 0) begin
                $display("ERROR at %0t: resolve_valid with no instruction outstanding", $time);
                error_count++;
            end else if (resolve_valid) begin
                want    = expect_q.pop_front();
                is_jump = jump_q.pop_front();
                compare_field("inst_num", resolve_out.inst_num, want.inst_num);
                compare_field("rd", word_t'(resolve_out.rd), word_t'(want.rd));
                compare_field("taken", word_t'(resolve_out.taken), word_t'(want.taken));
                compare_field("mispredict", word_t'(resolve_out.mispredict),
                              word_t'(want.mispredict));
                compare_field("redirect_pc", resolve_out.redirect_pc, want.redirect_pc);
                if (is_jump) begin
                    compare_field("link_data", resolve_out.link_data, want.link_data);
                end
            end
            // head issue uses operands held before this edge
            if (pending.size() > 0 && pending[0].src1_ready && pending[0].src2_ready) begin
                e = pending.pop_front();
                expect_q.push_back(expected_resolve(e));
                jump_q.push_back(e.is_jump);
            end
            foreach (pending[i]) begin
                pending[i] = wake(pending[i]);
            end
            if (dispatch_valid) begin
                pending.push_back(wake(dispatch_inst));
            end
        end
        outstanding = pending.size() + expect_q.size();
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import branch_pkg::*;

    localparam int RS_DEPTH     = 16;
    localparam int NUM_DISPATCH = 400;
    localparam int MAX_CYCLES   = NUM_DISPATCH * 40;
    localparam funct3_t F3_LIST [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    logic         clk = 1'b0;
    logic         reset;
    logic         dispatch_valid;
    br_dispatch_t dispatch_inst;
    cdb_result_t  alu_result;
    cdb_result_t  mul_result;
    cdb_result_t  div_result;
    cdb_result_t  load_result;
    logic         rs_full;
    logic         resolve_valid;
    br_resolve_t  resolve_out;
    int           error_count;
    int           outstanding;

    logic [31:0] rng_state;
    logic [15:0] waiting;  // tags that some entry still waits on
    int          cycle;
    int          dispatched;
    int          tb_errors;

    branch_exec_top #(.RS_DEPTH(RS_DEPTH)) uut (.*);

    tb_checker #(.RS_DEPTH(RS_DEPTH)) u_checker (.*);

    bind branch_exec_top branch_asserts #(.RS_DEPTH(RS_DEPTH)) u_asserts (
        .clk,
        .reset,
        .dispatch_valid,
        .rs_full,
        .issue_valid,
        .resolve_valid
    );

    always #50 clk = ~clk;

    // lcg step with the high half folded into the weak low bits
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state ^ (rng_state >> 16);
    endfunction

    function automatic word_t rand_word();
        logic [31:0] r;
        r = next_rand();
        return r[7] ? {{29{r[31]}}, r[2:0]} : next_rand();  // small values tie often
    endfunction

    task automatic drive_cycle();
        cdb_result_t buses [4];
        logic [31:0] r;
        logic [31:0] s;
        r = next_rand();
        s = next_rand();
        dispatch_valid = dispatched < NUM_DISPATCH && !rs_full && r[1:0] != 2'b00;
        if (dispatch_valid) begin
            dispatch_inst.inst_num   = dispatched;
            dispatch_inst.pc         = {s[31:2], 2'b00};
            dispatch_inst.rd         = r[27:20];
            dispatch_inst.is_jump    = r[4:2] == 3'b000;
            dispatch_inst.is_branch  = r[4:2] != 3'b000;
            dispatch_inst.funct3     = F3_LIST[r[7:5] % 3'd6];
            dispatch_inst.imm        = {{21{s[1]}}, s[11:2], 1'b0};
            dispatch_inst.src1       = {4'h0, r[11:8]};
            dispatch_inst.src2       = {4'h0, r[15:12]};
            dispatch_inst.src1_data  = rand_word();
            dispatch_inst.src2_data  = rand_word();
            dispatch_inst.src1_ready = r[16];
            dispatch_inst.src2_ready = r[17];
            dispatch_inst.pred_taken = r[18];
            dispatch_inst.btb_hit    = r[19];
            waiting[r[11:8]]  = waiting[r[11:8]] | !r[16];
            waiting[r[15:12]] = waiting[r[15:12]] | !r[17];
            dispatched++;
        end
        // quiet window starves the head so the station fills
        for (int k = 0; k < 4; k++) begin
            r = next_rand();
            buses[k].valid = (cycle % 300) >= 90 && waiting[r[3:0]] && r[9];
            buses[k].tag   = {4'h0, r[3:0]};
            buses[k].data  = rand_word();
        end
        for (int k = 0; k < 4; k++) begin
            if (buses[k].valid) begin
                waiting[buses[k].tag[3:0]] = 1'b0;
            end
        end
        alu_result  = buses[0];
        mul_result  = buses[1];
        div_result  = buses[2];
        load_result = buses[3];
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = uut.u_asserts.fail_count;
        $display("errors: %0d checker, %0d assertion, %0d testbench",
                 error_count, assert_errors, tb_errors);
        if (error_count == 0 && assert_errors == 0 && tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        rng_state      = 32'hfea4;
        waiting        = '0;
        cycle          = 0;
        dispatched     = 0;
        tb_errors      = 0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_inst  = '0;
        alu_result     = '0;
        mul_result     = '0;
        div_result     = '0;
        load_result    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (dispatched < NUM_DISPATCH || outstanding != 0) begin
            drive_cycle();
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
        finish_run();
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("ERROR: timeout, run did not finish within %0d cycles", MAX_CYCLES);
            tb_errors++;
            finish_run();
        end
    end

endmodule
